/* design/decodePkg.sv */
package decodePkg;

    localparam int instrWidth = 32;

    // Primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        opSpecial  = 6'b000000,
        opRegimm   = 6'b000001,
        opJ        = 6'b000010,
        opJal      = 6'b000011,
        opBeq      = 6'b000100,
        opBne      = 6'b000101,
        opBlez     = 6'b000110,
        opBgtz     = 6'b000111,
        opAddi     = 6'b001000,
        opAddiu    = 6'b001001,
        opSlti     = 6'b001010,
        opSltiu    = 6'b001011,
        opAndi     = 6'b001100,
        opOri      = 6'b001101,
        opXori     = 6'b001110,
        opLui      = 6'b001111,
        opSpecial2 = 6'b011100,
        opSpecial3 = 6'b011111, // seb, seh
        opLb       = 6'b100000,
        opLh       = 6'b100001,
        opLw       = 6'b100011,
        opSb       = 6'b101000,
        opSh       = 6'b101001,
        opSw       = 6'b101011
    } opcodeT;

    // SPECIAL funct codes, instr[5:0]
    typedef enum logic [5:0] {
        fnSll   = 6'b000000,
        fnSrl   = 6'b000010, // rotr when bit 21 set
        fnSra   = 6'b000011,
        fnSllv  = 6'b000100,
        fnSrlv  = 6'b000110, // rotrv when bits 10..6 = 1
        fnSrav  = 6'b000111,
        fnJr    = 6'b001000,
        fnMovz  = 6'b001010,
        fnMovn  = 6'b001011,
        fnMfhi  = 6'b010000,
        fnMthi  = 6'b010001,
        fnMflo  = 6'b010010,
        fnMtlo  = 6'b010011,
        fnMult  = 6'b011000,
        fnMultu = 6'b011001,
        fnAdd   = 6'b100000,
        fnAddu  = 6'b100001,
        fnSub   = 6'b100010,
        fnAnd   = 6'b100100,
        fnOr    = 6'b100101,
        fnXor   = 6'b100110,
        fnNor   = 6'b100111,
        fnSlt   = 6'b101010,
        fnSltu  = 6'b101011
    } functT;

    // SPECIAL2 codes share encodings with SPECIAL ones
    localparam functT fnMadd = fnSll;
    localparam functT fnMul  = fnSrl;
    localparam functT fnMsub = fnSllv;

    // Numbering matches the ALU operation select
    typedef enum logic [4:0] {
        aluAdd, aluSub, aluMult, aluAnd, aluOr, aluNor, aluXor, aluSll,
        aluSrl, aluRotr, aluSlt, aluMovn, aluMovz, aluSra, aluSltu, aluMthi,
        aluMtlo, aluMfhi, aluMflo, aluMul, aluMadd, aluMsub, aluSeh, aluSeb,
        aluBgez, aluBltz,
        aluNone = 5'd31
    } aluOpT;

    typedef enum logic [1:0] {dstRt, dstRd, dstRa} regDstT;
    typedef enum logic [1:0] {sizeWord, sizeHalf, sizeByte} dataTypeT;
    typedef enum logic [1:0] {hiLoNone, hiLoHi, hiLoLo, hiLoBoth} hiLoWriteT;
    typedef enum logic [1:0] {classSpecial, classSpecial2, classOther} instrClassT;

    typedef struct packed {
        regDstT    regDst;
        logic      aluSrc;     // Immediate as second operand
        logic      aluSrc2;    // Shamt as shift operand
        logic      memToReg;
        logic      regWrite;
        hiLoWriteT hiLoWrite;
        logic      memRead;
        logic      memWrite;
        logic      branch;
        logic      jump;
        dataTypeT  dataType;
        aluOpT     aluOp;
        logic      signExtend;
    } ctrlBundleT;

    localparam ctrlBundleT ctrlIdle = '{
        regDst:     dstRt,
        aluSrc:     1'b0,
        aluSrc2:    1'b0,
        memToReg:   1'b0,
        regWrite:   1'b0,
        hiLoWrite:  hiLoNone,
        memRead:    1'b0,
        memWrite:   1'b0,
        branch:     1'b0,
        jump:       1'b0,
        dataType:   sizeWord,
        aluOp:      aluNone,
        signExtend: 1'b0
    };

endpackage

/* design/decodeStage.sv */
`timescale 1ns/10ps

module decodeStage import decodePkg::*; (
    input  logic       clk,
    input  logic       arstN,
    input  logic       req,
    input  ctrlBundleT finalCtrl,
    output logic       ack,
    output ctrlBundleT ctrl
);

    // Four-phase handshake with the EX stage
    typedef enum logic {
        stIdle, // Waiting for req
        stHeld  // Bundle captured, ack high
    } hsStateT;

    hsStateT state;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= stIdle;
            ctrl  <= ctrlIdle;
        end else begin
            case (state)
                stIdle: begin
                    if (req) begin
                        ctrl  <= finalCtrl; // Capture on the first req edge
                        state <= stHeld;
                    end
                end
                stHeld: begin
                    // ctrl holds until the producer lets go
                    if (!req) begin
                        state <= stIdle;
                    end
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    assign ack = (state == stHeld);

endmodule

/* design/functDecoder.sv */
`timescale 1ns/10ps

module functDecoder import decodePkg::*; (
    input  logic [instrWidth-1:0] instr,
    input  instrClassT            instrClass,
    input  ctrlBundleT            baseCtrl,
    output ctrlBundleT            finalCtrl
);

    logic [5:0] funct;
    logic       bit21;
    logic [4:0] saField;

    assign funct   = instr[5:0];
    assign bit21   = instr[21];   // srl vs rotr
    assign saField = instr[10:6]; // srlv vs rotrv

    always_comb begin
        finalCtrl = baseCtrl;

        case (instrClass)
            classSpecial: begin
                finalCtrl.aluOp     = aluNone;
                finalCtrl.hiLoWrite = hiLoNone;
                finalCtrl.aluSrc2   = 1'b0;
                finalCtrl.jump      = 1'b0;

                case (funct)
                    fnAdd, fnAddu: finalCtrl.aluOp = aluAdd;
                    fnSub:         finalCtrl.aluOp = aluSub;
                    fnAnd:         finalCtrl.aluOp = aluAnd;
                    fnOr:          finalCtrl.aluOp = aluOr;
                    fnNor:         finalCtrl.aluOp = aluNor;
                    fnXor:         finalCtrl.aluOp = aluXor;
                    fnSlt:         finalCtrl.aluOp = aluSlt;
                    fnSltu:        finalCtrl.aluOp = aluSltu;
                    fnMovn:        finalCtrl.aluOp = aluMovn;
                    fnMovz:        finalCtrl.aluOp = aluMovz;
                    fnSra, fnSrav: finalCtrl.aluOp = aluSra;
                    fnSllv:        finalCtrl.aluOp = aluSll;
                    fnMfhi:        finalCtrl.aluOp = aluMfhi;
                    fnMflo:        finalCtrl.aluOp = aluMflo;
                    fnSll: begin
                        finalCtrl.aluOp   = aluSll;
                        finalCtrl.aluSrc2 = 1'b1;
                    end
                    fnSrl: begin
                        finalCtrl.aluOp   = bit21 ? aluRotr : aluSrl;
                        finalCtrl.aluSrc2 = 1'b1;
                    end
                    fnSrlv: begin
                        if (saField == 5'd0) begin
                            finalCtrl.aluOp = aluSrl;
                        end else if (saField == 5'd1) begin
                            finalCtrl.aluOp = aluRotr;
                        end
                    end
                    fnMult, fnMultu: begin
                        finalCtrl.aluOp     = aluMult;
                        finalCtrl.hiLoWrite = hiLoBoth;
                    end
                    fnMthi: begin
                        finalCtrl.aluOp     = aluMthi;
                        finalCtrl.hiLoWrite = hiLoHi;
                    end
                    fnMtlo: begin
                        finalCtrl.aluOp     = aluMtlo;
                        finalCtrl.hiLoWrite = hiLoLo;
                    end
                    fnJr:    finalCtrl.jump = 1'b1; // Target from rs
                    default: finalCtrl.aluOp = aluNone;
                endcase
            end

            classSpecial2: begin
                // Only the three multiply forms exist here
                finalCtrl.aluOp     = aluNone;
                finalCtrl.hiLoWrite = hiLoNone;
                if (funct == fnMul) begin
                    finalCtrl.aluOp = aluMul;
                end else if (funct == fnMadd) begin
                    finalCtrl.aluOp     = aluMadd;
                    finalCtrl.hiLoWrite = hiLoBoth;
                end else if (funct == fnMsub) begin
                    finalCtrl.aluOp     = aluMsub;
                    finalCtrl.hiLoWrite = hiLoBoth;
                end
            end

            default: begin
                finalCtrl = baseCtrl; // Opcode alone decides
            end
        endcase
    end

endmodule

/* design/instrDecodeTop.sv */
`timescale 1ns/10ps

module instrDecodeTop import decodePkg::*; (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic [instrWidth-1:0] instr,
    input  logic                  req,
    output logic                  ack,
    output ctrlBundleT            ctrl
);

    ctrlBundleT baseCtrl;
    ctrlBundleT finalCtrl;
    instrClassT instrClass;

    // Primary opcode and REGIMM decode
    opcodeDecoder opcodeDecoder_i (
        .instr      (instr),
        .baseCtrl   (baseCtrl),
        .instrClass (instrClass)
    );

    // SPECIAL / SPECIAL2 refinement
    functDecoder functDecoder_i (
        .instr      (instr),
        .instrClass (instrClass),
        .baseCtrl   (baseCtrl),
        .finalCtrl  (finalCtrl)
    );

    decodeStage decodeStage_i (
        .clk       (clk),
        .arstN     (arstN),
        .req       (req),
        .finalCtrl (finalCtrl),
        .ack       (ack),
        .ctrl      (ctrl)  // ID boundary
    );

endmodule

/* design/opcodeDecoder.sv */
`timescale 1ns/10ps

module opcodeDecoder import decodePkg::*; (
    input  logic [instrWidth-1:0] instr,
    output ctrlBundleT            baseCtrl,
    output instrClassT            instrClass
);

    logic [5:0] opcode;
    logic [4:0] rtField;
    logic [4:0] saField;

    assign opcode  = instr[31:26];
    assign rtField = instr[20:16]; // REGIMM branch select
    assign saField = instr[10:6];  // seb/seh select

    always_comb begin
        baseCtrl   = ctrlIdle;
        instrClass = classOther;

        case (opcode)
            opSpecial: begin
                // aluOp filled in by the funct stage
                baseCtrl.regDst   = dstRd;
                baseCtrl.regWrite = 1'b1;
                instrClass        = classSpecial;
            end

            opSpecial2: begin
                baseCtrl.regDst   = dstRd;
                baseCtrl.regWrite = 1'b1;
                instrClass        = classSpecial2;
            end

            opSpecial3: begin
                baseCtrl.regDst   = dstRd;
                baseCtrl.regWrite = 1'b1;
                if (saField == 5'b10000) begin
                    baseCtrl.aluOp = aluSeb;
                end else if (saField == 5'b11000) begin
                    baseCtrl.aluOp = aluSeh;
                end
            end

            opLw, opLh, opLb: begin
                baseCtrl.aluSrc   = 1'b1;
                baseCtrl.memToReg = 1'b1;
                baseCtrl.regWrite = 1'b1;
                baseCtrl.memRead  = 1'b1;
                baseCtrl.aluOp    = aluAdd; // Address = rs + offset
                baseCtrl.dataType = (opcode == opLw) ? sizeWord :
                                    (opcode == opLh) ? sizeHalf : sizeByte;
            end

            opSw, opSh, opSb: begin
                baseCtrl.aluSrc   = 1'b1;
                baseCtrl.memWrite = 1'b1;
                baseCtrl.aluOp    = aluAdd;
                baseCtrl.dataType = (opcode == opSw) ? sizeWord :
                                    (opcode == opSh) ? sizeHalf : sizeByte;
            end

            opLui, opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori: begin
                baseCtrl.aluSrc   = 1'b1;
                baseCtrl.regWrite = 1'b1;
                case (opcode)
                    opAddi, opAddiu: baseCtrl.aluOp = aluAdd;
                    opSlti:          baseCtrl.aluOp = aluSlt;
                    opSltiu:         baseCtrl.aluOp = aluSltu;
                    opAndi:          baseCtrl.aluOp = aluAnd;
                    opOri:           baseCtrl.aluOp = aluOr;
                    opXori:          baseCtrl.aluOp = aluXor;
                    default:         baseCtrl.aluOp = aluNone; // lui
                endcase
                // Logic immediates use the extension select
                baseCtrl.signExtend = (opcode == opAndi) || (opcode == opOri) ||
                                      (opcode == opXori);
            end

            opRegimm: begin
                baseCtrl.branch = 1'b1;
                if (rtField == 5'd1) begin
                    baseCtrl.aluOp = aluBgez;
                end else if (rtField == 5'd0) begin
                    baseCtrl.aluOp = aluBltz;
                end
            end

            opBeq, opBne, opBgtz, opBlez: begin
                baseCtrl.branch = 1'b1; // Compare done outside the ALU
            end

            opJ, opJal: begin
                baseCtrl.jump    = 1'b1;
                baseCtrl.aluSrc2 = 1'b1;
                baseCtrl.regDst  = (opcode == opJal) ? dstRa : dstRt;
            end

            default: begin
                baseCtrl = ctrlIdle; // Unknown opcode
            end
        endcase
    end

endmodule

/* flist.f */
design/decodePkg.sv
design/opcodeDecoder.sv
design/functDecoder.sv
design/decodeStage.sv
design/instrDecodeTop.sv
verification/decodeStageProperties.sv
verification/instrDecodeTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the decode stage testbench; exit status follows the simulation
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f flist.f --top-module instrDecodeTb \
    -Mdir obj_dir -o simv &&
./obj_dir/simv ||
{ echo "Simulation run did not complete cleanly"; exit 1; }

/* verification/decodeStageProperties.sv */
`timescale 1ns/10ps

module decodeStageProperties import decodePkg::*; (
    input logic       clk,
    input logic       arstN,
    input logic       req,
    input logic       ack,
    input ctrlBundleT ctrl
);

    // No req at this edge means ack stays low
    ackRiseNeedsReq: assert property (@(posedge clk) disable iff (!arstN)
        (!ack && !req) |=> !ack)
        else $error("ack rose while req was low");

    // Held req keeps ack high
    ackFallNeedsNoReq: assert property (@(posedge clk) disable iff (!arstN)
        (ack && req) |=> ack)
        else $error("ack fell while req was high");

    ctrlStableWhileAck: assert property (@(posedge clk) disable iff (!arstN)
        (ack && $past(ack)) |-> $stable(ctrl))
        else $error("ctrl changed while ack stayed high");

endmodule

bind decodeStage decodeStageProperties decodeStageProperties_i (
    .clk   (clk),
    .arstN (arstN),
    .req   (req),
    .ack   (ack),
    .ctrl  (ctrl)
);

/* verification/instrDecodeTb.sv */
`timescale 1ns/10ps

module instrDecodeTb import decodePkg::*; ();

    localparam int maxWait  = 10;  // Cycles allowed for any ack edge
    localparam int numTrans = 400;

    localparam opcodeT opList [24] = '{
        opSpecial, opRegimm, opJ, opJal, opBeq, opBne, opBlez, opBgtz,
        opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui,
        opSpecial2, opSpecial3, opLb, opLh, opLw, opSb, opSh, opSw
    };
    localparam functT specialFns [24] = '{
        fnSll, fnSrl, fnSra, fnSllv, fnSrlv, fnSrav, fnJr, fnMovz,
        fnMovn, fnMfhi, fnMthi, fnMflo, fnMtlo, fnMult, fnMultu, fnAdd,
        fnAddu, fnSub, fnAnd, fnOr, fnXor, fnNor, fnSlt, fnSltu
    };
    localparam functT special2Fns [3] = '{fnMul, fnMadd, fnMsub};
    localparam logic [4:0] saChoices [4] = '{5'd0, 5'd1, 5'd16, 5'd24}; // srlv, seb, seh selects

    logic        clk;
    logic        arstN;
    logic [31:0] instr;
    logic        req;
    logic        ack;
    ctrlBundleT  ctrl;

    instrDecodeTop dut_i (
        .clk   (clk),
        .arstN (arstN),
        .instr (instr),
        .req   (req),
        .ack   (ack),
        .ctrl  (ctrl)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stopWithFailure();
        $display("Done: errors found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch in %s: expected %h, actual %h", testName, expected, actual);
            stopWithFailure();
        end
    endtask

    // Counts falling edges until ack reaches the wanted level
    task automatic waitForAck(input logic level, output int cycles);
        cycles = 0;
        while (ack !== level) begin
            if (cycles >= maxWait) begin
                $display("Timed out after %0d cycles waiting for ack to become %b",
                         maxWait, level);
                stopWithFailure();
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
    endtask

    function automatic aluOpT specialAluOp(logic [5:0] fn, logic rotate, logic [4:0] sa);
        aluOpT op;
        case (fn)
            fnAdd, fnAddu:   op = aluAdd;
            fnSub:           op = aluSub;
            fnAnd:           op = aluAnd;
            fnOr:            op = aluOr;
            fnNor:           op = aluNor;
            fnXor:           op = aluXor;
            fnSlt:           op = aluSlt;
            fnSltu:          op = aluSltu;
            fnMovn:          op = aluMovn;
            fnMovz:          op = aluMovz;
            fnSll, fnSllv:   op = aluSll;
            fnSra, fnSrav:   op = aluSra;
            fnSrl:           op = rotate ? aluRotr : aluSrl; // Bit 21 picks rotr
            fnSrlv:          op = (sa == 5'd0) ? aluSrl : (sa == 5'd1) ? aluRotr : aluNone;
            fnMult, fnMultu: op = aluMult;
            fnMthi:          op = aluMthi;
            fnMtlo:          op = aluMtlo;
            fnMfhi:          op = aluMfhi;
            fnMflo:          op = aluMflo;
            default:         op = aluNone; // jr and unknown functs
        endcase
        return op;
    endfunction

    // Reference decode of one instruction word
    function automatic ctrlBundleT refDecode(logic [31:0] word);
        logic [5:0] op;
        logic [5:0] fn;
        ctrlBundleT c;
        op = word[31:26];
        fn = word[5:0];
        c  = ctrlIdle;
        if (op == opSpecial || op == opSpecial2 || op == opSpecial3) begin
            c.regDst   = dstRd;
            c.regWrite = 1'b1;
        end
        case (op)
            opSpecial: begin
                c.aluOp   = specialAluOp(fn, word[21], word[10:6]);
                c.aluSrc2 = (fn == fnSll) || (fn == fnSrl); // Shamt forms only
                c.jump    = (fn == fnJr);
                if (fn == fnMult || fn == fnMultu) c.hiLoWrite = hiLoBoth;
                else if (fn == fnMthi) c.hiLoWrite = hiLoHi;
                else if (fn == fnMtlo) c.hiLoWrite = hiLoLo;
            end
            opSpecial2: begin
                c.aluOp = (fn == fnMul) ? aluMul : (fn == fnMadd) ? aluMadd :
                          (fn == fnMsub) ? aluMsub : aluNone;
                if (fn == fnMadd || fn == fnMsub) c.hiLoWrite = hiLoBoth;
            end
            opSpecial3: begin
                c.aluOp = (word[10:6] == 5'd16) ? aluSeb :
                          (word[10:6] == 5'd24) ? aluSeh : aluNone;
            end
            opLb, opLh, opLw, opSb, opSh, opSw: begin
                c.aluSrc   = 1'b1;
                c.aluOp    = aluAdd;
                c.memRead  = !op[3];  // Loads sit below the stores
                c.memWrite = op[3];
                c.memToReg = !op[3];
                c.regWrite = !op[3];
                c.dataType = (op[1:0] == 2'b11) ? sizeWord :
                             (op[1:0] == 2'b01) ? sizeHalf : sizeByte;
            end
            opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui: begin
                c.aluSrc     = 1'b1;
                c.regWrite   = 1'b1;
                c.signExtend = (op == opAndi) || (op == opOri) || (op == opXori);
                c.aluOp = (op == opAddi || op == opAddiu) ? aluAdd :
                          (op == opSlti) ? aluSlt : (op == opSltiu) ? aluSltu :
                          (op == opAndi) ? aluAnd : (op == opOri) ? aluOr :
                          (op == opXori) ? aluXor : aluNone;
            end
            opRegimm: begin
                c.branch = 1'b1;
                c.aluOp  = (word[20:16] == 5'd1) ? aluBgez :
                           (word[20:16] == 5'd0) ? aluBltz : aluNone;
            end
            opBeq, opBne, opBlez, opBgtz: c.branch = 1'b1;
            opJ, opJal: begin
                c.jump    = 1'b1;
                c.aluSrc2 = 1'b1;
                if (op == opJal) c.regDst = dstRa; // Link register
            end
            default: c = ctrlIdle;
        endcase
        return c;
    endfunction

    function automatic logic [31:0] randomInstr();
        logic [31:0] word;
        logic [4:0]  opIdx;
        logic [4:0]  fnIdx;
        logic [1:0]  smallIdx;
        word = $urandom();
        if ($urandom_range(0, 99) < 80) begin
            opIdx       = 5'($urandom_range(0, 23));
            word[31:26] = opList[opIdx];
            if (opList[opIdx] == opSpecial) begin
                fnIdx     = 5'($urandom_range(0, 23));
                word[5:0] = specialFns[fnIdx];
            end else if (opList[opIdx] == opSpecial2) begin
                smallIdx  = 2'($urandom_range(0, 2));
                word[5:0] = special2Fns[smallIdx];
            end
            // Steer sa and rt toward their select values half the time
            if ($urandom_range(0, 1) == 1) begin
                smallIdx    = 2'($urandom_range(0, 3));
                word[10:6]  = saChoices[smallIdx];
                word[20:16] = {4'b0000, smallIdx[0]};
            end
        end
        return word;
    endfunction

    task automatic runTransaction(input logic [31:0] word);
        ctrlBundleT expected;
        string      name;
        int         cycles;
        int         holdCycles;
        expected = refDecode(word);
        name     = $sformatf("decode %08h", word);
        instr    = word;
        req      = 1'b1;
        waitForAck(1'b1, cycles);
        checkValue("ackRise", 1, cycles);
        checkValue(name, 32'(expected), 32'(ctrl));
        holdCycles = $urandom_range(0, 4); // Producer back-pressure
        instr      = randomInstr();        // Captured bundle must not follow instr
        repeat (holdCycles) begin
            @(negedge clk);
            checkValue("ackHold", 1, 32'(ack));
            checkValue("ctrlHold", 32'(expected), 32'(ctrl));
        end
        req = 1'b0;
        waitForAck(1'b0, cycles);
        checkValue("ackFall", 1, cycles);
        repeat ($urandom_range(0, 2)) @(negedge clk);
    endtask

    initial begin
        void'($urandom(54206));
        arstN = 1'b0;
        req   = 1'b0;
        instr = '0;
        repeat (2) @(negedge clk);
        checkValue("resetAck", 0, 32'(ack));
        checkValue("resetCtrl", 32'(ctrlIdle), 32'(ctrl));
        arstN = 1'b1;
        @(negedge clk);
        checkValue("idleCtrl", 32'(ctrlIdle), 32'(ctrl));
        for (int t = 0; t < numTrans; t++) begin
            runTransaction(randomInstr());
        end
        $display("Done: no errors");
        $finish;
    end

endmodule
